// ==== common/up_pkg.sv ====
`default_nettype none

package up_pkg;

  localparam int UP_ADDR_WIDTH = 14;

  typedef logic [UP_ADDR_WIDTH-1:0] up_addr_t;  // Word address on the internal bus.
  typedef logic [31:0]              up_data_t;
  typedef logic [31:0]              axi_addr_t; // AXI byte address.
  typedef logic [1:0]               axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
  localparam up_data_t  UP_TIMEOUT_DATA = 32'hdeaddead;

  // ~~~~~~~~~~~~~~~~~~~~
  // Register word addresses.
  // ~~~~~~~~~~~~~~~~~~~~
  localparam up_addr_t REG_VERSION = 14'h0000;
  localparam up_addr_t REG_ID      = 14'h0001;
  localparam up_addr_t REG_SCRATCH = 14'h0002;
  localparam up_addr_t REG_WCOUNT  = 14'h0003;

  typedef struct packed {
    logic     wreq;
    up_addr_t waddr;
    up_data_t wdata;
  } up_wr_req_t;

  typedef struct packed {
    logic     rreq;
    up_addr_t raddr;
  } up_rd_req_t;

  typedef struct packed {
    logic     rack;
    up_data_t rdata; // Valid in the rack cycle only.
  } up_rd_rsp_t;

endpackage

`default_nettype wire

// ==== dv/tb_up_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_up_core;

  localparam int               TIMEOUT_CYCLES = 8;
  localparam up_pkg::up_data_t CORE_VERSION   = 32'h00010002;
  localparam up_pkg::up_data_t CORE_ID        = 32'h0000005a;
  localparam int               WAIT_LIMIT     = 100;
  localparam up_pkg::up_addr_t UNDECODED      = 14'h0100;

  typedef struct packed {
    logic             is_write;
    up_pkg::up_addr_t addr;
    up_pkg::up_data_t data; // Write data, or the expected read data.
    logic [3:0]       hold; // Cycles of response back-pressure.
  } row_t;

  logic              up_clk;
  logic              up_rstn;
  logic              up_axi_awvalid;
  up_pkg::axi_addr_t up_axi_awaddr;
  logic              up_axi_awready;
  logic              up_axi_wvalid;
  up_pkg::up_data_t  up_axi_wdata;
  logic [3:0]        up_axi_wstrb;
  logic              up_axi_wready;
  logic              up_axi_bvalid;
  up_pkg::axi_resp_t up_axi_bresp;
  logic              up_axi_bready;
  logic              up_axi_arvalid;
  up_pkg::axi_addr_t up_axi_araddr;
  logic              up_axi_arready;
  logic              up_axi_rvalid;
  up_pkg::axi_resp_t up_axi_rresp;
  up_pkg::up_data_t  up_axi_rdata;
  logic              up_axi_rready;

  row_t              table_q[$];
  up_pkg::up_data_t  scratch_model;
  up_pkg::up_data_t  wcount_model;
  integer            seed;

  up_core #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .CORE_VERSION   (CORE_VERSION),
    .CORE_ID        (CORE_ID)
  ) i_dut (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_axi_awvalid (up_axi_awvalid),
    .up_axi_awaddr  (up_axi_awaddr),
    .up_axi_awready (up_axi_awready),
    .up_axi_wvalid  (up_axi_wvalid),
    .up_axi_wdata   (up_axi_wdata),
    .up_axi_wstrb   (up_axi_wstrb),
    .up_axi_wready  (up_axi_wready),
    .up_axi_bvalid  (up_axi_bvalid),
    .up_axi_bresp   (up_axi_bresp),
    .up_axi_bready  (up_axi_bready),
    .up_axi_arvalid (up_axi_arvalid),
    .up_axi_araddr  (up_axi_araddr),
    .up_axi_arready (up_axi_arready),
    .up_axi_rvalid  (up_axi_rvalid),
    .up_axi_rresp   (up_axi_rresp),
    .up_axi_rdata   (up_axi_rdata),
    .up_axi_rready  (up_axi_rready)
  );

  always #2 up_clk = ~up_clk;

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Gave up after %0d cycles waiting for %s.", WAIT_LIMIT, what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic up_pkg::up_data_t expected_read(input up_pkg::up_addr_t addr);
    if (addr >= 14'h0010) begin
      return up_pkg::UP_TIMEOUT_DATA; // Nobody answers, so the bridge times out.
    end
    case (addr)
      up_pkg::REG_VERSION: return CORE_VERSION;
      up_pkg::REG_ID:      return CORE_ID;
      up_pkg::REG_SCRATCH: return scratch_model;
      up_pkg::REG_WCOUNT:  return wcount_model;
      default:             return 32'h00000000;
    endcase
  endfunction

  task automatic add_write(input up_pkg::up_addr_t addr, input up_pkg::up_data_t data,
                           input logic [3:0] hold);
    table_q.push_back('{is_write: 1'b1, addr: addr, data: data, hold: hold});
    if (addr < 14'h0010) begin
      wcount_model = wcount_model + 32'd1;
      if (addr == up_pkg::REG_SCRATCH) begin
        scratch_model = data;
      end
    end
  endtask

  task automatic add_read(input up_pkg::up_addr_t addr, input logic [3:0] hold);
    table_q.push_back('{is_write: 1'b0, addr: addr, data: expected_read(addr), hold: hold});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite master
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic axi_write(input up_pkg::up_addr_t addr, input up_pkg::up_data_t data,
                           input logic [3:0] hold);
    int cycles;
    cycles         = 0;
    up_axi_awaddr  = {16'h0000, addr, 2'b00};
    up_axi_wdata   = data;
    up_axi_awvalid = 1'b1;
    up_axi_wvalid  = 1'b1;
    while (!up_axi_awready) begin
      @(posedge up_clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("awready on a write");
    end
    check(32'(up_axi_wready), 32'd1, "wready together with awready");
    up_axi_awvalid = 1'b0;
    up_axi_wvalid  = 1'b0;
    cycles         = 0;
    while (!up_axi_bvalid) begin
      @(posedge up_clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("bvalid on a write");
    end
    repeat (hold) begin
      @(posedge up_clk);
      #1;
      check(32'(up_axi_bvalid), 32'd1, "bvalid under back-pressure");
    end
    check(32'(up_axi_bresp), 32'(up_pkg::AXI_RESP_OKAY), "bresp");
    up_axi_bready = 1'b1;
    @(posedge up_clk);
    #1;
    up_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input up_pkg::up_addr_t addr, input logic [3:0] hold,
                          output up_pkg::up_data_t data);
    int               cycles;
    up_pkg::up_data_t first;
    cycles         = 0;
    up_axi_araddr  = {16'h0000, addr, 2'b00};
    up_axi_arvalid = 1'b1;
    while (!up_axi_arready) begin
      @(posedge up_clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("arready on a read");
    end
    up_axi_arvalid = 1'b0;
    cycles         = 0;
    while (!up_axi_rvalid) begin
      @(posedge up_clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("rvalid on a read");
    end
    first = up_axi_rdata;
    repeat (hold) begin
      @(posedge up_clk);
      #1;
      check(32'(up_axi_rvalid), 32'd1, "rvalid under back-pressure");
      check(up_axi_rdata, first, "rdata under back-pressure");
    end
    check(32'(up_axi_rresp), 32'(up_pkg::AXI_RESP_OKAY), "rresp");
    data          = up_axi_rdata;
    up_axi_rready = 1'b1;
    @(posedge up_clk);
    #1;
    up_axi_rready = 1'b0;
  endtask

  initial begin
    up_pkg::up_data_t rdata;
    up_clk         = 1'b0;
    up_rstn        = 1'b0;
    up_axi_awvalid = 1'b0;
    up_axi_awaddr  = '0;
    up_axi_wvalid  = 1'b0;
    up_axi_wdata   = '0;
    up_axi_wstrb   = 4'hf; // Ignored by the bridge.
    up_axi_bready  = 1'b0;
    up_axi_arvalid = 1'b0;
    up_axi_araddr  = '0;
    up_axi_rready  = 1'b0;
    seed           = 89762;
    scratch_model  = '0;
    wcount_model   = '0;
    repeat (4) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;
    check(32'(up_axi_bvalid), 32'd0, "bvalid after reset");
    check(32'(up_axi_rvalid), 32'd0, "rvalid after reset");

    add_read(up_pkg::REG_VERSION, 4'd0);
    add_read(up_pkg::REG_ID, 4'd0);
    repeat (4) begin
      add_write(up_pkg::REG_SCRATCH, $random(seed), 4'd0);
      add_read(up_pkg::REG_SCRATCH, 4'd0);
    end
    add_write(up_pkg::REG_VERSION, $random(seed), 4'd0); // Read-only, still counted.
    add_read(up_pkg::REG_VERSION, 4'd0);
    add_read(up_pkg::REG_WCOUNT, 4'd0);
    add_read(UNDECODED, 4'd0);
    add_write(UNDECODED, $random(seed), 4'd0);
    add_read(up_pkg::REG_WCOUNT, 4'd0);
    add_read(up_pkg::REG_SCRATCH, 4'd0);
    // Responses held back by the master.
    add_write(up_pkg::REG_SCRATCH, $random(seed), 4'd5);
    add_read(up_pkg::REG_SCRATCH, 4'd6);
    add_read(up_pkg::REG_WCOUNT, 4'd3);
    add_read(14'h0007, 4'd0);

    foreach (table_q[i]) begin
      if (table_q[i].is_write) begin
        axi_write(table_q[i].addr, table_q[i].data, table_q[i].hold);
      end else begin
        axi_read(table_q[i].addr, table_q[i].hold, rdata);
        check(rdata, table_q[i].data, $sformatf("read of word %h", table_q[i].addr));
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/up_axi_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_axi_assertions (
  input logic               up_clk,
  input logic               up_rstn,
  input logic               up_axi_awready,
  input logic               up_axi_wready,
  input logic               up_axi_bvalid,
  input logic               up_axi_bready,
  input logic               up_axi_rvalid,
  input logic               up_axi_rready,
  input up_pkg::up_data_t   up_axi_rdata,
  input up_pkg::up_wr_req_t wr_req,
  input up_pkg::up_rd_req_t rd_req
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Response channels
  // ~~~~~~~~~~~~~~~~~~~~

  bvalid_held: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_axi_bvalid && !up_axi_bready |=> up_axi_bvalid)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_axi_rvalid && !up_axi_rready |=> up_axi_rvalid && $stable(up_axi_rdata))
    else $error("rvalid or rdata changed before rready");

  // Requests on the internal bus last one cycle.
  wreq_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    wr_req.wreq |=> !wr_req.wreq)
    else $error("wreq longer than one cycle");

  rreq_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    rd_req.rreq |=> !rd_req.rreq)
    else $error("rreq longer than one cycle");

  // Both ready signals pulse with the rise of bvalid.
  aw_w_ready: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_axi_awready |-> up_axi_wready && $rose(up_axi_bvalid))
    else $error("awready without wready or a rising bvalid");

endmodule

bind up_axi up_axi_assertions i_up_axi_assertions (
  .up_clk         (up_clk),
  .up_rstn        (up_rstn),
  .up_axi_awready (up_axi_awready),
  .up_axi_wready  (up_axi_wready),
  .up_axi_bvalid  (up_axi_bvalid),
  .up_axi_bready  (up_axi_bready),
  .up_axi_rvalid  (up_axi_rvalid),
  .up_axi_rready  (up_axi_rready),
  .up_axi_rdata   (up_axi_rdata),
  .wr_req         (wr_req),
  .rd_req         (rd_req)
);

`default_nettype wire

// ==== list.f ====
common/up_pkg.sv
up_axi/up_axi.sv
rtl/up_regmap.sv
rtl/up_core.sv
dv/up_axi_assertions.sv
dv/tb_up_core.sv

// ==== rtl/up_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_core #(
  parameter int               TIMEOUT_CYCLES = 8,
  parameter up_pkg::up_data_t CORE_VERSION   = 32'h00000000,
  parameter up_pkg::up_data_t CORE_ID        = 32'h00000000
) (
  input  logic              up_clk,
  input  logic              up_rstn,

  input  logic              up_axi_awvalid,
  input  up_pkg::axi_addr_t up_axi_awaddr,
  output logic              up_axi_awready,
  input  logic              up_axi_wvalid,
  input  up_pkg::up_data_t  up_axi_wdata,
  input  logic [3:0]        up_axi_wstrb,
  output logic              up_axi_wready,
  output logic              up_axi_bvalid,
  output up_pkg::axi_resp_t up_axi_bresp,
  input  logic              up_axi_bready,
  input  logic              up_axi_arvalid,
  input  up_pkg::axi_addr_t up_axi_araddr,
  output logic              up_axi_arready,
  output logic              up_axi_rvalid,
  output up_pkg::axi_resp_t up_axi_rresp,
  output up_pkg::up_data_t  up_axi_rdata,
  input  logic              up_axi_rready
);

  up_pkg::up_wr_req_t wr_req;
  up_pkg::up_rd_req_t rd_req;
  up_pkg::up_rd_rsp_t rd_rsp;
  logic               wack;

  up_axi #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_up_axi (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_axi_awvalid (up_axi_awvalid),
    .up_axi_awaddr  (up_axi_awaddr),
    .up_axi_awready (up_axi_awready),
    .up_axi_wvalid  (up_axi_wvalid),
    .up_axi_wdata   (up_axi_wdata),
    .up_axi_wstrb   (up_axi_wstrb),
    .up_axi_wready  (up_axi_wready),
    .up_axi_bvalid  (up_axi_bvalid),
    .up_axi_bresp   (up_axi_bresp),
    .up_axi_bready  (up_axi_bready),
    .up_axi_arvalid (up_axi_arvalid),
    .up_axi_araddr  (up_axi_araddr),
    .up_axi_arready (up_axi_arready),
    .up_axi_rvalid  (up_axi_rvalid),
    .up_axi_rresp   (up_axi_rresp),
    .up_axi_rdata   (up_axi_rdata),
    .up_axi_rready  (up_axi_rready),
    .wr_req         (wr_req),
    .wack           (wack),
    .rd_req         (rd_req),
    .rd_rsp         (rd_rsp)
  );

  // The map answers decoded words only, so the bridge times out on the rest.
  up_regmap #(
    .CORE_VERSION (CORE_VERSION),
    .CORE_ID      (CORE_ID)
  ) i_up_regmap (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .wr_req  (wr_req),
    .wack    (wack),
    .rd_req  (rd_req),
    .rd_rsp  (rd_rsp)
  );

endmodule

`default_nettype wire

// ==== rtl/up_regmap.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_regmap #(
  parameter up_pkg::up_data_t CORE_VERSION = 32'h00000000,
  parameter up_pkg::up_data_t CORE_ID      = 32'h00000000
) (
  input  logic               up_clk,
  input  logic               up_rstn,

  input  up_pkg::up_wr_req_t wr_req,
  output logic               wack,
  input  up_pkg::up_rd_req_t rd_req,
  output up_pkg::up_rd_rsp_t rd_rsp
);

  logic             wdec;
  logic             rdec;
  up_pkg::up_data_t scratch;
  up_pkg::up_data_t wcount;
  up_pkg::up_data_t rdata_mux;
  logic             rack_q;
  up_pkg::up_data_t rdata_q;

  // Only the lowest sixteen words are decoded.
  assign wdec = (wr_req.waddr[up_pkg::UP_ADDR_WIDTH-1:4] == '0);
  assign rdec = (rd_req.raddr[up_pkg::UP_ADDR_WIDTH-1:4] == '0);

  assign rd_rsp = '{rack: rack_q, rdata: rdata_q};

  // ~~~~~~~~~~~~~~~~~~~~
  // Writes
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      wack    <= 1'b0;
      wcount  <= '0;
      scratch <= '0;
    end else begin
      wack <= wr_req.wreq && wdec;
      if (wr_req.wreq && wdec) begin
        wcount <= wcount + 1'b1; // Counts every decoded write, read-only words too.
        if (wr_req.waddr == up_pkg::REG_SCRATCH) begin
          scratch <= wr_req.wdata;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Reads
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (rd_req.raddr)
      up_pkg::REG_VERSION: rdata_mux = CORE_VERSION;
      up_pkg::REG_ID:      rdata_mux = CORE_ID;
      up_pkg::REG_SCRATCH: rdata_mux = scratch;
      up_pkg::REG_WCOUNT:  rdata_mux = wcount;
      default:             rdata_mux = '0; // Reserved words read as zero.
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      rack_q <= 1'b0;
    end else begin
      rack_q <= rd_req.rreq && rdec;
    end
  end

  always_ff @(posedge up_clk) begin
    rdata_q <= rdata_mux;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  --top-module tb_up_core \
  -f list.f

./obj_dir/Vtb_up_core 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed, see sim.log."
  exit 1
fi

// ==== up_axi/up_axi.sv ====
`timescale 1ns/1ps
`default_nettype none

module up_axi #(
  parameter int TIMEOUT_CYCLES = 8
) (
  input  logic                  up_clk,
  input  logic                  up_rstn,

  input  logic                  up_axi_awvalid,
  input  up_pkg::axi_addr_t     up_axi_awaddr,
  output logic                  up_axi_awready,
  input  logic                  up_axi_wvalid,
  input  up_pkg::up_data_t      up_axi_wdata,
  input  logic [3:0]            up_axi_wstrb,
  output logic                  up_axi_wready,
  output logic                  up_axi_bvalid,
  output up_pkg::axi_resp_t     up_axi_bresp,
  input  logic                  up_axi_bready,
  input  logic                  up_axi_arvalid,
  input  up_pkg::axi_addr_t     up_axi_araddr,
  output logic                  up_axi_arready,
  output logic                  up_axi_rvalid,
  output up_pkg::axi_resp_t     up_axi_rresp,
  output up_pkg::up_data_t      up_axi_rdata,
  input  logic                  up_axi_rready,

  output up_pkg::up_wr_req_t    wr_req,
  input  logic                  wack,
  output up_pkg::up_rd_req_t    rd_req,
  input  up_pkg::up_rd_rsp_t    rd_rsp
);

  localparam int CNT_WIDTH = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(TIMEOUT_CYCLES - 1);

  logic                 wsel;
  logic                 wreq;
  up_pkg::up_addr_t     waddr;
  up_pkg::up_data_t     wdata;
  logic                 wpend;
  logic [CNT_WIDTH-1:0] wcnt;
  logic                 wtimeout;
  logic                 wack_sel;
  logic                 wack_int;

  logic                 rsel;
  logic                 rreq;
  up_pkg::up_addr_t     raddr;
  logic                 rpend;
  logic [CNT_WIDTH-1:0] rcnt;
  logic                 rtimeout;
  logic                 rack_sel;
  logic                 rack_int;
  up_pkg::up_data_t     rdata_int;

  // Strobes are accepted and ignored, so every write is a full word.
  assign up_axi_bresp = up_pkg::AXI_RESP_OKAY;
  assign up_axi_rresp = up_pkg::AXI_RESP_OKAY;

  assign wr_req = '{wreq: wreq, waddr: waddr, wdata: wdata};
  assign rd_req = '{rreq: rreq, raddr: raddr};

  // ~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~

  // The count reaches the last value only if the map stayed silent.
  assign wtimeout = wpend && !wack && (wcnt == CNT_LAST);
  assign wack_sel = (wpend && wack) || wtimeout;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      wsel     <= 1'b0;
      wreq     <= 1'b0;
      wpend    <= 1'b0;
      wcnt     <= '0;
      wack_int <= 1'b0;
    end else begin
      if (wsel) begin
        if (up_axi_bvalid && up_axi_bready) begin
          wsel <= 1'b0; // Free again after the response handshake.
        end
        wreq <= 1'b0;
      end else begin
        wsel <= up_axi_awvalid && up_axi_wvalid;
        wreq <= up_axi_awvalid && up_axi_wvalid;
      end
      wpend <= wreq || (wpend && !wack_sel);
      if (wreq) begin
        wcnt <= CNT_WIDTH'(1);
      end else if (wpend) begin
        wcnt <= wcnt + 1'b1;
      end
      wack_int <= wack_sel;
    end
  end

  always_ff @(posedge up_clk) begin
    if (!wsel) begin
      waddr <= up_axi_awaddr[up_pkg::UP_ADDR_WIDTH+1:2]; // Byte to word address.
      wdata <= up_axi_wdata;
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_axi_awready <= 1'b0;
      up_axi_wready  <= 1'b0;
      up_axi_bvalid  <= 1'b0;
    end else begin
      up_axi_awready <= wack_int;
      up_axi_wready  <= wack_int;
      if (wack_int) begin
        up_axi_bvalid <= 1'b1;
      end else if (up_axi_bready) begin
        up_axi_bvalid <= 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~

  assign rtimeout = rpend && !rd_rsp.rack && (rcnt == CNT_LAST);
  assign rack_sel = (rpend && rd_rsp.rack) || rtimeout;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      rsel     <= 1'b0;
      rreq     <= 1'b0;
      rpend    <= 1'b0;
      rcnt     <= '0;
      rack_int <= 1'b0;
    end else begin
      if (rsel) begin
        if (up_axi_rvalid && up_axi_rready) begin
          rsel <= 1'b0;
        end
        rreq <= 1'b0;
      end else begin
        rsel <= up_axi_arvalid;
        rreq <= up_axi_arvalid;
      end
      rpend <= rreq || (rpend && !rack_sel);
      if (rreq) begin
        rcnt <= CNT_WIDTH'(1);
      end else if (rpend) begin
        rcnt <= rcnt + 1'b1;
      end
      rack_int <= rack_sel;
    end
  end

  always_ff @(posedge up_clk) begin
    if (!rsel) begin
      raddr <= up_axi_araddr[up_pkg::UP_ADDR_WIDTH+1:2];
    end
    rdata_int <= rtimeout ? up_pkg::UP_TIMEOUT_DATA : rd_rsp.rdata;
    if (rack_int) begin
      up_axi_rdata <= rdata_int; // Held until the next read completes.
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_axi_arready <= 1'b0;
      up_axi_rvalid  <= 1'b0;
    end else begin
      up_axi_arready <= rack_sel;
      if (rack_int) begin
        up_axi_rvalid <= 1'b1;
      end else if (up_axi_rready) begin
        up_axi_rvalid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
